/* Makefile */
# Verilator simulation of the load/store unit

SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := lsu_tb
FILELIST := files.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(SIM), run $(TOP) and check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^all tests passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/lsu_asserts.sv */
// Load/store unit checker for done timing, write suppression and busy versus state

`timescale 1ns/1ps

module lsu_asserts import lsu_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,
    // Request side
    input  logic       req_i,
    input  logic       busy_i,
    input  logic       done_i,
    // Controller internals
    input  lsu_state_t state_i,
    input  logic       misaligned_i,
    // Memory line at the held index
    input  xlen_t      mem_line_i
);

    // ------------------------------------------------------------------------
    // Response timing
    // ------------------------------------------------------------------------

    // Done follows an accepted request by exactly two edges
    done_two_edges: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        done_i == $past(req_i && !busy_i, 2))
        else $error("done_o does not follow request acceptance by two edges");

    // Single cycle pulse
    done_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        done_i |=> !done_i)
        else $error("done_o held high for more than one cycle");

    // ------------------------------------------------------------------------
    // Memory and status
    // ------------------------------------------------------------------------

    // Misaligned access leaves the addressed line untouched
    no_misaligned_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (state_i == ACCESS && misaligned_i) |=> $stable(mem_line_i))
        else $error("memory line changed by a misaligned access");

    // Busy over ACCESS and RESP after acceptance, low again back in IDLE
    busy_follows_request: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (req_i && !busy_i) |=> (busy_i && state_i == ACCESS)
            ##1 (busy_i && state_i == RESP) ##1 (!busy_i && state_i == IDLE))
        else $error("busy_o or the controller state off the request sequence");

    // Without a request the unit stays idle
    idle_without_request: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (!busy_i && !req_i) |=> (!busy_i && state_i == IDLE))
        else $error("unit left IDLE without a request");

endmodule

/* bench/lsu_tb.sv */
// Load/store unit testbench with seeded random requests checked against a byte model

`timescale 1ns/1ps

module lsu_tb import lsu_pkg::*; ();

    // Run length and cycle limit
    localparam int RAND_REQS      = 2000;
    localparam int TIMEOUT_CYCLES = (MEM_WORDS + RAND_REQS) * 4 + 100;

    logic     clk_i;
    logic     rst_n_i;
    logic     req_i;
    logic     is_store_i;
    ls_type_t type_i;
    xlen_t    base_i;
    imm_t     imm_i;
    xlen_t    wdata_i;
    logic     busy_o;
    logic     done_o;
    logic     misaligned_o;
    xlen_t    rdata_o;

    // Byte image of the data memory
    logic [7:0] model_mem [1 << ADDR_W];
    int         cycle_count;
    int         seed_dummy;

    lsu_top UUT (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .req_i        (req_i),
        .is_store_i   (is_store_i),
        .type_i       (type_i),
        .base_i       (base_i),
        .imm_i        (imm_i),
        .wdata_i      (wdata_i),
        .busy_o       (busy_o),
        .done_o       (done_o),
        .misaligned_o (misaligned_o),
        .rdata_o      (rdata_o)
    );

    bind lsu_top lsu_asserts u_asserts (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .req_i        (req_i),
        .busy_i       (busy_o),
        .done_i       (done_o),
        .state_i      (state),
        .misaligned_i (held_misaligned),
        .mem_line_i   (u_data_mem.mem[word_idx])
    );

    // ------------------------------------------------------------------------
    // Clock and cycle limit
    // ------------------------------------------------------------------------

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles without finishing the run", cycle_count);
            $display("tests failed");
            $fatal(1, "cycle limit reached");
        end
    end

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------

    // Access size in bytes
    function automatic int access_bytes(ls_type_t t);
        case (t)
            LS_BYTE, LS_BYTE_U:         return 1;
            LS_HALFWORD, LS_HALFWORD_U: return 2;
            LS_WORD, LS_WORD_U:         return 4;
            default:                    return 8;
        endcase
    endfunction

    function automatic logic is_misaligned(ls_type_t t, addr_t a);
        return (int'(a) % access_bytes(t)) != 0;
    endfunction

    // Little endian gather, then extend from the field's top bit
    function automatic xlen_t model_load(ls_type_t t, addr_t a);
        xlen_t val;
        int    n;
        n   = access_bytes(t);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val[8*i +: 8] = model_mem[a + addr_t'(i)];
        end
        if ((t == LS_BYTE || t == LS_HALFWORD || t == LS_WORD) && val[8*n-1]) begin
            for (int i = n; i < 8; i++) begin
                val[8*i +: 8] = 8'hff;
            end
        end
        return val;
    endfunction

    task automatic model_store(ls_type_t t, addr_t a, xlen_t wdata);
        for (int i = 0; i < access_bytes(t); i++) begin
            model_mem[a + addr_t'(i)] = wdata[8*i +: 8];
        end
    endtask

    // Random upper bits, low bits land on the target after the offset add
    function automatic xlen_t base_for(addr_t target, xlen_t hi, imm_t imm);
        xlen_t imm_sext;
        imm_sext = {{(XLEN-12){imm[11]}}, imm};
        return xlen_t'(target) - imm_sext + {hi[XLEN-1:ADDR_W], {ADDR_W{1'b0}}};
    endfunction

    // About one in four sized accesses pushed off alignment
    function automatic addr_t shape_address(ls_type_t t, addr_t a);
        addr_t mask;
        addr_t low;
        mask = addr_t'(access_bytes(t) - 1);
        low  = '0;
        if (mask != '0 && $urandom_range(0, 3) == 0) begin
            low = addr_t'($urandom_range(1, access_bytes(t) - 1));
        end
        return (a & ~mask) | low;
    endfunction

    // ------------------------------------------------------------------------
    // Checking and request driving
    // ------------------------------------------------------------------------

    task automatic check_value(string name, xlen_t got, xlen_t exp);
        if (got !== exp) begin
            $display("Error at time %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("tests failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic run_request(logic st, ls_type_t t, addr_t target);
        imm_t  imm;
        xlen_t base;
        xlen_t wdata;
        xlen_t exp_data;
        logic  exp_mis;
        int    edges;
        imm      = imm_t'($urandom);
        base     = base_for(target, {$urandom, $urandom}, imm);
        wdata    = {$urandom, $urandom};
        exp_mis  = is_misaligned(t, target);
        exp_data = (st || exp_mis) ? '0 : model_load(t, target);
        // New requests only once the unit is idle
        while (busy_o) begin
            @(posedge clk_i);
            #1;
        end
        req_i      = 1'b1;
        is_store_i = st;
        type_i     = t;
        base_i     = base;
        imm_i      = imm;
        wdata_i    = wdata;
        edges      = 0;
        do begin
            @(posedge clk_i);
            #1;
            edges++;
            if (edges == 1) begin
                check_value("busy_o", xlen_t'(busy_o), 64'd1);
                check_value("done_o", xlen_t'(done_o), 64'd0);
                // Sometimes a stray request while busy, which must be dropped
                req_i = ($urandom_range(0, 1) == 1);
                is_store_i = ($urandom_range(0, 1) == 1);
                type_i     = ls_type_t'($urandom_range(0, 6));
                base_i     = {$urandom, $urandom};
                imm_i      = imm_t'($urandom);
                wdata_i    = {$urandom, $urandom};
            end
        end while (!done_o && edges < 8);
        req_i = 1'b0;
        if (!done_o) begin
            $display("Request at time %0t got no done_o within 8 cycles", $time);
            $display("tests failed");
            $fatal(1, "missing done");
        end
        check_value("done_o latency", xlen_t'(edges), 64'd2);
        check_value("busy_o", xlen_t'(busy_o), 64'd1);
        check_value("misaligned_o", xlen_t'(misaligned_o), xlen_t'(exp_mis));
        check_value("rdata_o", rdata_o, exp_data);
        if (st && !exp_mis) begin
            model_store(t, target, wdata);
        end
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------

    initial begin
        logic     st;
        ls_type_t t;
        addr_t    target;
        int       n;
        seed_dummy  = $urandom(32'h5bc937e0);
        cycle_count = 0;
        rst_n_i     = 1'b0;
        req_i       = 1'b0;
        is_store_i  = 1'b0;
        type_i      = LS_BYTE;
        base_i      = '0;
        imm_i       = '0;
        wdata_i     = '0;
        repeat (5) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;

        // Quiet after reset until the first request
        repeat (3) begin
            check_value("busy_o", xlen_t'(busy_o), 64'd0);
            check_value("done_o", xlen_t'(done_o), 64'd0);
            @(posedge clk_i);
            #1;
        end

        // Known content in every line
        for (int i = 0; i < MEM_WORDS; i++) begin
            run_request(1'b1, LS_DOUBLEWORD, addr_t'(i * 8));
        end

        // Random mix, each store read back as a full line
        n = 0;
        while (n < RAND_REQS) begin
            st     = ($urandom_range(0, 1) == 1);
            t      = ls_type_t'($urandom_range(0, 6));
            target = shape_address(t, addr_t'($urandom));
            run_request(st, t, target);
            n++;
            if (st && n < RAND_REQS) begin
                run_request(1'b0, LS_DOUBLEWORD, {target[ADDR_W-1:BYTE_OFF_W], 3'b000});
                n++;
            end
        end

        @(posedge clk_i);
        #1;
        check_value("busy_o", xlen_t'(busy_o), 64'd0);
        $display("all tests passed");
        $finish;
    end

endmodule

/* files.f */
source/lsu_pkg.sv
source/lsu_ctrl.sv
source/addr_gen.sv
source/store_aligner.sv
source/byte_selector.sv
source/data_mem.sv
source/lsu_top.sv
bench/lsu_asserts.sv
bench/lsu_tb.sv

/* source/addr_gen.sv */
// Address stage that holds the request, forms the byte address and flags misalignment

`timescale 1ns/1ps

module addr_gen import lsu_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    // Load the request on this strobe
    input  logic      capture_i,
    // Request fields
    input  logic      is_store_i,
    input  ls_type_t  type_i,
    input  xlen_t     base_i,
    input  imm_t      imm_i,
    input  xlen_t     wdata_i,
    // Held request
    output logic      is_store_o,
    output ls_type_t  type_o,
    output word_idx_t word_idx_o,
    output byte_off_t byte_off_o,
    output xlen_t     wdata_o,
    output logic      misaligned_o
);

    // Offset widened with its sign bit
    xlen_t imm_sext;
    // Full sum and its cut to the address width
    xlen_t sum;
    addr_t addr_d;
    addr_t addr_q;

    assign imm_sext = {{(XLEN-12){imm_i[11]}}, imm_i};
    assign sum      = base_i + imm_sext;
    assign addr_d   = sum[ADDR_W-1:0];

    // --------------------------------------------------------------------------
    // Request registers
    // --------------------------------------------------------------------------

    // Control fields cleared by reset
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            is_store_o <= 1'b0;
            type_o     <= LS_BYTE;
        end else if (capture_i) begin
            is_store_o <= is_store_i;
            type_o     <= type_i;
        end
    end

    // Address and store data payload
    always_ff @(posedge clk_i) begin
        if (capture_i) begin
            addr_q  <= addr_d;
            wdata_o <= wdata_i;
        end
    end

    // Line index above, byte lane below
    assign word_idx_o = addr_q[ADDR_W-1:BYTE_OFF_W];
    assign byte_off_o = addr_q[BYTE_OFF_W-1:0];

    // Alignment rule per access size
    always_comb begin
        case (type_o)
            LS_HALFWORD, LS_HALFWORD_U: misaligned_o = addr_q[0];
            LS_WORD, LS_WORD_U:         misaligned_o = |addr_q[1:0];
            LS_DOUBLEWORD:              misaligned_o = |addr_q[2:0];
            default:                    misaligned_o = 1'b0;
        endcase
    end

endmodule

/* source/byte_selector.sv */
// Load byte selector that extracts the addressed field of a line and extends it

`timescale 1ns/1ps

module byte_selector import lsu_pkg::*; (
    // Access size and lane offset
    input  ls_type_t  type_i,
    input  byte_off_t byte_off_i,
    // Line read from memory
    input  xlen_t     line_i,
    // Low for stores and misaligned accesses
    input  logic      is_load_i,
    // Load result
    output xlen_t     line_o
);

    // Field picked at each mux level
    logic [31:0] sel_w;
    logic [15:0] sel_h;
    logic [7:0]  sel_b;

    // --------------------------------------------------------------------------
    // Field selection
    // --------------------------------------------------------------------------

    // Offset bit 2 picks the word
    assign sel_w = byte_off_i[2] ? line_i[63:32] : line_i[31:0];

    // Offset bit 1 picks the halfword inside it
    assign sel_h = byte_off_i[1] ? sel_w[31:16] : sel_w[15:0];

    // Offset bit 0 picks the byte inside that
    assign sel_b = byte_off_i[0] ? sel_h[15:8] : sel_h[7:0];

    // --------------------------------------------------------------------------
    // Extension
    // --------------------------------------------------------------------------

    always_comb begin
        if (!is_load_i) begin
            // Nothing to return
            line_o = '0;
        end else begin
            case (type_i)
                // Byte
                LS_BYTE:       line_o = {{(XLEN-8){sel_b[7]}}, sel_b};
                LS_BYTE_U:     line_o = {{(XLEN-8){1'b0}}, sel_b};
                // Halfword
                LS_HALFWORD:   line_o = {{(XLEN-16){sel_h[15]}}, sel_h};
                LS_HALFWORD_U: line_o = {{(XLEN-16){1'b0}}, sel_h};
                // Word
                LS_WORD:       line_o = {{(XLEN-32){sel_w[31]}}, sel_w};
                LS_WORD_U:     line_o = {{(XLEN-32){1'b0}}, sel_w};
                // Doubleword passes the line as is
                LS_DOUBLEWORD: line_o = line_i;
                default:       line_o = line_i;
            endcase
        end
    end

endmodule

/* source/data_mem.sv */
// Doubleword data memory with byte-enable writes and a registered read port

`timescale 1ns/1ps

module data_mem import lsu_pkg::*; (
    input  logic      clk_i,
    // Access strobes
    input  logic      en_i,
    input  logic      we_i,
    // Line index
    input  word_idx_t idx_i,
    // Lane enables and write line
    input  be_t       be_i,
    input  xlen_t     wdata_i,
    // Read line, one edge after en_i
    output xlen_t     rdata_o
);

    // --------------------------------------------------------------------------
    // Storage
    // --------------------------------------------------------------------------

    // One line per doubleword
    xlen_t mem [MEM_WORDS];

    // Write lanes, one per enable bit
    always_ff @(posedge clk_i) begin
        if (en_i && we_i) begin
            for (int i = 0; i < XLEN/8; i++) begin
                if (be_i[i]) begin
                    mem[idx_i][i*8 +: 8] <= wdata_i[i*8 +: 8];
                end
            end
        end
    end

    // --------------------------------------------------------------------------
    // Read port
    // --------------------------------------------------------------------------

    // Old line on a write cycle
    // holds its value while disabled
    always_ff @(posedge clk_i) begin
        if (en_i) begin
            rdata_o <= mem[idx_i];
        end
    end

endmodule

/* source/lsu_ctrl.sv */
// Load/store controller FSM that accepts a request, runs the memory access and flags completion

`timescale 1ns/1ps

module lsu_ctrl import lsu_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,
    // Request strobe from outside
    input  logic       req_i,
    // Held request attributes from the address stage
    input  logic       is_store_i,
    input  logic       misaligned_i,
    // Request capture into the address stage
    output logic       capture_o,
    // Memory strobes
    output logic       mem_en_o,
    output logic       mem_we_o,
    // Status towards the requester
    output logic       busy_o,
    output logic       done_o,
    // Current state, for checking only
    output lsu_state_t state_o
);

    // Present and next state
    lsu_state_t state_q;
    lsu_state_t state_d;

    // --------------------------------------------------------------------------
    // State register
    // --------------------------------------------------------------------------

    // Synchronous active low reset back to IDLE
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // --------------------------------------------------------------------------
    // Next state
    // --------------------------------------------------------------------------

    // Fixed walk IDLE, ACCESS, RESP, one state per cycle
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                // Leave only on a new request
                if (req_i) begin
                    state_d = ACCESS;
                end
            end
            ACCESS: begin
                // Memory strobe goes out in this cycle
                state_d = RESP;
            end
            RESP: begin
                // Response is presented, back to waiting
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // --------------------------------------------------------------------------
    // Outputs
    // --------------------------------------------------------------------------

    // Requests while busy are dropped here
    assign capture_o = (state_q == IDLE) && req_i;

    // No memory activity for a misaligned access
    assign mem_en_o  = (state_q == ACCESS) && !misaligned_i;

    // Write only for an aligned store
    assign mem_we_o  = (state_q == ACCESS) && is_store_i && !misaligned_i;

    // Busy over ACCESS and RESP
    assign busy_o    = (state_q != IDLE);

    // One cycle done pulse with valid read data
    assign done_o    = (state_q == RESP);

    assign state_o   = state_q;

endmodule

/* source/lsu_pkg.sv */
// Load/store unit package with widths, access type codes and the control state enum

package lsu_pkg;

    // --------------------------------------------------------------------------
    // Widths and sizes
    // --------------------------------------------------------------------------

    // Data path width
    localparam int unsigned XLEN = 64;

    // Memory depth in doublewords
    localparam int unsigned MEM_WORDS = 256;

    // Byte offset inside one doubleword line
    localparam int unsigned BYTE_OFF_W = $clog2(XLEN / 8);

    // Index of one doubleword line
    localparam int unsigned WORD_IDX_W = $clog2(MEM_WORDS);

    // Full byte address, index on top of offset
    localparam int unsigned ADDR_W = WORD_IDX_W + BYTE_OFF_W;

    // --------------------------------------------------------------------------
    // Vector types
    // --------------------------------------------------------------------------

    // Data value, register value or memory line
    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [WORD_IDX_W-1:0] word_idx_t;
    typedef logic [BYTE_OFF_W-1:0] byte_off_t;

    // One enable bit per byte lane
    typedef logic [XLEN/8-1:0] be_t;

    // Access type code
    typedef logic [2:0] ls_type_t;

    // Signed 12-bit address offset
    typedef logic [11:0] imm_t;

    // --------------------------------------------------------------------------
    // Access type codes
    // --------------------------------------------------------------------------

    // Stores treat each unsigned code like its signed twin
    localparam ls_type_t LS_BYTE       = 3'd0;
    localparam ls_type_t LS_BYTE_U     = 3'd1;
    localparam ls_type_t LS_HALFWORD   = 3'd2;
    localparam ls_type_t LS_HALFWORD_U = 3'd3;
    localparam ls_type_t LS_WORD       = 3'd4;
    localparam ls_type_t LS_WORD_U     = 3'd5;
    localparam ls_type_t LS_DOUBLEWORD = 3'd6;

    // Controller states, one per cycle of a request
    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        RESP
    } lsu_state_t;

endpackage

/* source/lsu_top.sv */
// Load/store unit top level joining the controller with the address, memory and load datapath

`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n_i,
    // Request
    input  logic     req_i,
    input  logic     is_store_i,
    input  ls_type_t type_i,
    input  xlen_t    base_i,
    input  imm_t     imm_i,
    input  xlen_t    wdata_i,
    // Response
    output logic     busy_o,
    output logic     done_o,
    output logic     misaligned_o,
    output xlen_t    rdata_o
);

    // --------------------------------------------------------------------------
    // Internal wiring
    // --------------------------------------------------------------------------

    // Controller strobes
    logic       capture;
    logic       mem_en;
    logic       mem_we;
    lsu_state_t state;

    // Held request
    logic       held_store;
    logic       held_misaligned;
    ls_type_t   held_type;
    word_idx_t  word_idx;
    byte_off_t  byte_off;
    xlen_t      held_wdata;

    // Memory side lines
    xlen_t      mem_wdata;
    be_t        mem_be;
    xlen_t      mem_rdata;

    // Result is zero for stores and misaligned accesses
    logic       is_load;

    assign is_load      = !held_store && !held_misaligned;
    assign misaligned_o = held_misaligned;

    // Controller
    lsu_ctrl u_ctrl (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .req_i        (req_i),
        .is_store_i   (held_store),
        .misaligned_i (held_misaligned),
        .capture_o    (capture),
        .mem_en_o     (mem_en),
        .mem_we_o     (mem_we),
        .busy_o       (busy_o),
        .done_o       (done_o),
        .state_o      (state)
    );

    // Request hold and address
    addr_gen u_addr_gen (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .capture_i    (capture),
        .is_store_i   (is_store_i),
        .type_i       (type_i),
        .base_i       (base_i),
        .imm_i        (imm_i),
        .wdata_i      (wdata_i),
        .is_store_o   (held_store),
        .type_o       (held_type),
        .word_idx_o   (word_idx),
        .byte_off_o   (byte_off),
        .wdata_o      (held_wdata),
        .misaligned_o (held_misaligned)
    );

    // Store lane placement
    store_aligner u_store_aligner (
        .type_i     (held_type),
        .byte_off_i (byte_off),
        .wdata_i    (held_wdata),
        .wdata_o    (mem_wdata),
        .be_o       (mem_be)
    );

    // Data memory
    data_mem u_data_mem (
        .clk_i   (clk_i),
        .en_i    (mem_en),
        .we_i    (mem_we),
        .idx_i   (word_idx),
        .be_i    (mem_be),
        .wdata_i (mem_wdata),
        .rdata_o (mem_rdata)
    );

    // Load field extraction
    byte_selector u_byte_selector (
        .type_i     (held_type),
        .byte_off_i (byte_off),
        .line_i     (mem_rdata),
        .is_load_i  (is_load),
        .line_o     (rdata_o)
    );

endmodule

/* source/store_aligner.sv */
// Store aligner that places store data on its byte lanes and builds the byte enables

`timescale 1ns/1ps

module store_aligner import lsu_pkg::*; (
    // Access size and lane offset
    input  ls_type_t  type_i,
    input  byte_off_t byte_off_i,
    // Store data, low bytes significant
    input  xlen_t     wdata_i,
    // Line data and lane enables to memory
    output xlen_t     wdata_o,
    output be_t       be_o
);

    // --------------------------------------------------------------------------
    // Lane data
    // --------------------------------------------------------------------------

    // Replicating the field puts a copy in every lane of its size,
    // so the enabled lane always sees the right bytes
    always_comb begin
        case (type_i)
            LS_BYTE, LS_BYTE_U: begin
                wdata_o = {(XLEN/8){wdata_i[7:0]}};
            end
            LS_HALFWORD, LS_HALFWORD_U: begin
                wdata_o = {(XLEN/16){wdata_i[15:0]}};
            end
            LS_WORD, LS_WORD_U: begin
                wdata_o = {(XLEN/32){wdata_i[31:0]}};
            end
            default: begin
                // Doubleword and unused code
                wdata_o = wdata_i;
            end
        endcase
    end

    // --------------------------------------------------------------------------
    // Byte enables
    // --------------------------------------------------------------------------

    // Contiguous mask of the access size moved to the offset
    always_comb begin
        case (type_i)
            LS_BYTE, LS_BYTE_U: begin
                be_o = be_t'(8'b0000_0001) << byte_off_i;
            end
            LS_HALFWORD, LS_HALFWORD_U: begin
                be_o = be_t'(8'b0000_0011) << byte_off_i;
            end
            LS_WORD, LS_WORD_U: begin
                be_o = be_t'(8'b0000_1111) << byte_off_i;
            end
            LS_DOUBLEWORD: begin
                // Whole line, offset is zero when aligned
                be_o = '1;
            end
            default: begin
                // Unused code writes nothing
                be_o = '0;
            end
        endcase
    end

endmodule
